// File: design/saturn_cfg.svh
//*********************************************************************
// build constants for the nibble-serial decoder.
// addresses count nibbles, not bytes, and wrap at 2^SAT_ADDR_W.
// SAT_OPERAND_NIBBLES must hold the longest LC operand (16 nibbles).
//*********************************************************************
`ifndef SATURN_CFG_SVH
`define SATURN_CFG_SVH

`define SAT_ADDR_W          20      // nibble address width.
`define SAT_NIBBLE_W        4
`define SAT_OPERAND_NIBBLES 16      // LC 15 carries 16 nibbles.
`define SAT_QUEUE_DEPTH     2       // records held at the output.
`define SAT_RESET_PC        20'h00000

`endif

// File: design/saturn_pkg.sv
//*********************************************************************
// types shared by the decoder RTL and its testbench.
// enum literals carry a group prefix since several groups share names.
//*********************************************************************
`default_nettype none

`include "saturn_cfg.svh"

package saturn_pkg;

    typedef enum logic [2:0] {
        ITYPE_ALU, ITYPE_LOAD, ITYPE_JUMP, ITYPE_RTN, ITYPE_SET_MODE
    } instr_type_e;

    typedef enum logic [2:0] {
        ALU_OP_NOP, ALU_OP_COPY, ALU_OP_SET_CRY, ALU_OP_CLR_MASK, ALU_OP_ZERO
    } alu_op_e;

    // A..D first so that the low bits of the A-group op nibble select them.
    typedef enum logic [3:0] {
        ALU_REG_A, ALU_REG_B, ALU_REG_C, ALU_REG_D, ALU_REG_P,
        ALU_REG_ST, ALU_REG_HST, ALU_REG_IMM, ALU_REG_NONE = 4'hF
    } alu_reg_e;

    // values 0..7 equal the 3-bit field code of the A/B group.
    typedef enum logic [3:0] {
        FIELD_P, FIELD_WP, FIELD_XS, FIELD_X, FIELD_S, FIELD_M, FIELD_B, FIELD_W,
        FIELD_NONE = 4'hF
    } field_e;

    typedef struct packed {
        logic [`SAT_ADDR_W-1:0]                        pc;
        instr_type_e                                   itype;
        alu_op_e                                       opcode;
        alu_reg_e                                      dest;
        alu_reg_e                                      src;
        field_e                                        field;
        logic [3:0]                                    ptr_begin;
        logic [3:0]                                    ptr_end;
        logic [3:0]                                    imm;
        logic                                          push_pc;
        logic [`SAT_OPERAND_NIBBLES*`SAT_NIBBLE_W-1:0] operand;   // first nibble lowest.
        logic [4:0]                                    operand_len;
    } decoded_instr_t;

endpackage

`default_nettype wire

// File: design/saturn_nibble_if.sv
//*********************************************************************
// nibble stream from fetch to decoder.
// a nibble moves on an edge with valid and ready high; nibble and
// addr hold while valid waits for ready.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

interface saturn_nibble_if;
    logic                     valid;
    logic                     ready;
    logic [`SAT_NIBBLE_W-1:0] nibble;
    logic [`SAT_ADDR_W-1:0]   addr;     // address of this nibble.

    modport fetch  (output valid, nibble, addr, input ready);
    modport decode (input valid, nibble, addr, output ready);
endinterface

`default_nettype wire

// File: design/saturn_nibble_fetch.sv
//*********************************************************************
// Wishbone classic reader, one bus cycle per nibble.
// fetch is strictly sequential from SAT_RESET_PC; jumps are not taken.
// a new cycle starts only once the held nibble is taken.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

module saturn_nibble_fetch (
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    output      logic                     o_wb_cyc,
    output      logic                     o_wb_stb,
    output      logic [`SAT_ADDR_W-1:0]   o_wb_adr,
    input  wire logic [`SAT_NIBBLE_W-1:0] i_wb_dat,
    input  wire logic                     i_wb_ack,
    saturn_nibble_if.fetch                nib
);

    logic [`SAT_ADDR_W-1:0] pc_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_cyc  <= 1'b0;
            nib.valid <= 1'b0;
            pc_q      <= `SAT_RESET_PC;
        end else if (o_wb_cyc) begin
            if (i_wb_ack) begin
                o_wb_cyc  <= 1'b0;      // cycle ends on ack.
                nib.valid <= 1'b1;
            end
        end else if (!nib.valid) begin
            o_wb_cyc <= 1'b1;           // first read after reset.
        end else if (nib.ready) begin
            nib.valid <= 1'b0;
            pc_q      <= pc_q + 1'b1;   // wraps at 2^20.
            o_wb_cyc  <= 1'b1;
        end
    end

    // holding register, loaded when the slave answers.
    always_ff @(posedge i_clk) begin
        if (o_wb_cyc && i_wb_ack)
            nib.nibble <= i_wb_dat;
    end

    assign o_wb_stb = o_wb_cyc;
    assign o_wb_adr = pc_q;
    assign nib.addr = pc_q;             // pc only moves once the nibble is taken.

endmodule

`default_nettype wire

// File: design/saturn_field_table.sv
//*********************************************************************
// A/B group field table; purely combinational.
// field P and WP follow the consumer's P register as given.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

module saturn_field_table
    import saturn_pkg::*;
(
    input  wire logic [2:0] i_code,
    input  wire logic [3:0] i_reg_p,
    output      field_e     o_field,
    output      logic [3:0] o_ptr_begin,
    output      logic [3:0] o_ptr_end
);

    always_comb begin
        o_field = field_e'({1'b0, i_code});
        case (i_code)
            3'd0:    begin o_ptr_begin = i_reg_p; o_ptr_end = i_reg_p; end   // P.
            3'd1:    begin o_ptr_begin = 4'h0;    o_ptr_end = i_reg_p; end   // WP.
            3'd2:    begin o_ptr_begin = 4'h2;    o_ptr_end = 4'h2;    end   // XS.
            3'd3:    begin o_ptr_begin = 4'h0;    o_ptr_end = 4'h2;    end   // X.
            3'd4:    begin o_ptr_begin = 4'hF;    o_ptr_end = 4'hF;    end   // S.
            3'd5:    begin o_ptr_begin = 4'h3;    o_ptr_end = 4'hE;    end   // mantissa.
            3'd6:    begin o_ptr_begin = 4'h0;    o_ptr_end = 4'h1;    end   // B.
            default: begin o_ptr_begin = 4'h0;    o_ptr_end = 4'hF;    end   // W.
        endcase
    end

endmodule

`default_nettype wire

// File: design/saturn_inst_decoder.sv
//*********************************************************************
// prefix-tree decoder, one nibble per clock.
// a record is pushed with the last nibble of its instruction; while
// the queue is full that nibble is refused.
// an unknown opcode stops decoding until reset.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

module saturn_inst_decoder
    import saturn_pkg::*;
(
    input  wire logic           i_clk,
    input  wire logic           i_reset,
    input  wire logic [3:0]     i_reg_p,
    saturn_nibble_if.decode     nib,
    output      logic           o_push,
    output      decoded_instr_t o_record,
    input  wire logic           i_full,
    output      logic           o_decoder_error
);

    typedef enum logic [3:0] {
        ST_START, ST_0X, ST_2X, ST_3X, ST_8X, ST_82X, ST_84X,
        ST_A_FIELD, ST_A_OP, ST_OPERAND, ST_ERROR
    } state_e;

    state_e         state_q, state_next;
    decoded_instr_t rec_q;
    logic [3:0]     cnt_q, cnt_next;    // operand nibbles gathered so far.
    logic           done, illegal, take;
    field_e         ft_field;
    logic [3:0]     ft_begin, ft_end;
    logic [3:0]     n;

    assign n = nib.nibble;

    saturn_field_table field_table_i (
        .i_code      (n[2:0]),
        .i_reg_p     (i_reg_p),
        .o_field     (ft_field),
        .o_ptr_begin (ft_begin),
        .o_ptr_end   (ft_end)
    );

    always_comb begin
        o_record   = rec_q;
        state_next = state_q;
        cnt_next   = cnt_q;
        done       = 1'b0;
        illegal    = 1'b0;
        case (state_q)
            ST_START: begin
                o_record = '{pc: nib.addr, itype: ITYPE_ALU, opcode: ALU_OP_NOP,
                             dest: ALU_REG_NONE, src: ALU_REG_NONE, field: FIELD_NONE,
                             default: '0};
                cnt_next = 4'd0;
                case (n)
                    4'h0: state_next = ST_0X;
                    4'h2: state_next = ST_2X;
                    4'h3: state_next = ST_3X;
                    4'h6: begin                             // short GOTO.
                        o_record.itype       = ITYPE_JUMP;
                        o_record.operand_len = 5'd3;
                        state_next           = ST_OPERAND;
                    end
                    4'h8: state_next = ST_8X;
                    4'hA: state_next = ST_A_FIELD;
                    default: illegal = 1'b1;
                endcase
            end
            ST_0X: begin
                done = 1'b1;
                if (n == 4'h2 || n == 4'h3) begin            // RTNSC / RTNCC.
                    o_record.itype  = ITYPE_RTN;
                    o_record.opcode = ALU_OP_SET_CRY;
                    o_record.imm    = {3'b000, ~n[0]};
                end else if (n == 4'h4 || n == 4'h5) begin   // SETHEX / SETDEC.
                    o_record.itype = ITYPE_SET_MODE;
                    o_record.imm   = {3'b000, n[0]};
                end else begin
                    done    = 1'b0;
                    illegal = 1'b1;
                end
            end
            ST_2X: begin                                    // P= n.
                o_record.opcode = ALU_OP_COPY;
                o_record.dest   = ALU_REG_P;
                o_record.src    = ALU_REG_IMM;
                o_record.imm    = n;
                done            = 1'b1;
            end
            ST_3X: begin                                    // LC, n+1 nibbles follow.
                o_record.itype       = ITYPE_LOAD;
                o_record.dest        = ALU_REG_C;
                o_record.ptr_begin   = i_reg_p;
                o_record.ptr_end     = i_reg_p + n;
                o_record.operand_len = {1'b0, n} + 5'd1;
                state_next           = ST_OPERAND;
            end
            ST_8X: begin
                case (n)
                    4'h2: state_next = ST_82X;
                    4'h4, 4'h5: begin                       // ST=0 / ST=1.
                        o_record.opcode = ALU_OP_COPY;
                        o_record.dest   = ALU_REG_ST;
                        o_record.src    = ALU_REG_IMM;
                        o_record.imm    = {3'b000, n[0]};
                        state_next      = ST_84X;
                    end
                    4'hD, 4'hF: begin                       // GOVLNG / GOSBVL.
                        o_record.itype       = ITYPE_JUMP;
                        o_record.push_pc     = n[1];
                        o_record.operand_len = 5'd5;
                        state_next           = ST_OPERAND;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            ST_82X: begin                                   // clear HST bits.
                o_record.opcode = ALU_OP_CLR_MASK;
                o_record.dest   = ALU_REG_HST;
                o_record.src    = ALU_REG_IMM;
                o_record.imm    = n;
                done            = 1'b1;
            end
            ST_84X: begin
                o_record.ptr_begin = n;                     // status bit number.
                o_record.ptr_end   = n;
                done               = 1'b1;
            end
            ST_A_FIELD: begin
                o_record.field     = ft_field;
                o_record.ptr_begin = ft_begin;
                o_record.ptr_end   = ft_end;
                illegal            = n[3];                  // Aa group not kept.
                state_next         = ST_A_OP;
            end
            ST_A_OP: begin
                o_record.opcode = ALU_OP_ZERO;
                o_record.dest   = alu_reg_e'({2'b00, n[1:0]});
                done            = (n[3:2] == 2'b10);
                illegal         = !done;
            end
            ST_OPERAND: begin
                o_record.operand[cnt_q*`SAT_NIBBLE_W +: `SAT_NIBBLE_W] = n;
                cnt_next = cnt_q + 4'd1;
                done     = ({1'b0, cnt_q} + 5'd1 == rec_q.operand_len);
            end
            default: ;                                      // ST_ERROR holds.
        endcase
        if (done)
            state_next = ST_START;
        if (illegal)
            state_next = ST_ERROR;
    end

    assign nib.ready       = (state_q != ST_ERROR) && !(done && i_full);
    assign take            = nib.valid && nib.ready;
    assign o_push          = take && done;
    assign o_decoder_error = (state_q == ST_ERROR);  // sticky until reset.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= ST_START;
            cnt_q   <= 4'd0;
        end else if (take) begin
            state_q <= state_next;
            cnt_q   <= cnt_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take)
            rec_q <= o_record;
    end

endmodule

`default_nettype wire

// File: design/saturn_decoded_queue.sv
//*********************************************************************
// record FIFO of SAT_QUEUE_DEPTH entries with valid/ready output.
// the writer must not push while o_full is high.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

module saturn_decoded_queue
    import saturn_pkg::*;
(
    input  wire logic           i_clk,
    input  wire logic           i_reset,
    input  wire logic           i_push,
    input  wire decoded_instr_t i_record,
    output      logic           o_full,
    output      logic           o_valid,
    input  wire logic           i_ready,
    output      decoded_instr_t o_record
);

    localparam int DEPTH = `SAT_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    decoded_instr_t           mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr, rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                     wr_en, rd_en;

    assign o_full   = (count == DEPTH);
    assign o_valid  = (count != 0);
    assign o_record = mem[rd_ptr];      // head stays put until taken.
    assign wr_en    = i_push && !o_full;
    assign rd_en    = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en)
            mem[wr_ptr] <= i_record;
    end

endmodule

`default_nettype wire

// File: design/saturn_decoder_top.sv
//*********************************************************************
// decoder top: Wishbone fetch, decoder and record queue.
// jumps are reported, not followed; the consumer redirects fetch.
// i_reg_p must hold the consumer's current P register.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

module saturn_decoder_top
    import saturn_pkg::*;
(
    input  wire logic                                          i_clk,
    input  wire logic                                          i_reset,
    output      logic                                          o_wb_cyc,
    output      logic                                          o_wb_stb,
    output      logic [`SAT_ADDR_W-1:0]                        o_wb_adr,
    input  wire logic [`SAT_NIBBLE_W-1:0]                      i_wb_dat,
    input  wire logic                                          i_wb_ack,
    input  wire logic [3:0]                                    i_reg_p,
    output      logic [`SAT_ADDR_W-1:0]                        o_instr_pc,
    output      instr_type_e                                   o_instr_type,
    output      alu_op_e                                       o_alu_opcode,
    output      alu_reg_e                                      o_alu_reg_dest,
    output      alu_reg_e                                      o_alu_reg_src,
    output      field_e                                        o_alu_field,
    output      logic [3:0]                                    o_alu_ptr_begin,
    output      logic [3:0]                                    o_alu_ptr_end,
    output      logic [3:0]                                    o_alu_imm,
    output      logic                                          o_push_pc,
    output      logic [`SAT_OPERAND_NIBBLES*`SAT_NIBBLE_W-1:0] o_operand,
    output      logic [4:0]                                    o_operand_len,
    output      logic                                          o_valid,
    input  wire logic                                          i_ready,
    output      logic                                          o_decoder_error
);

    saturn_nibble_if nib_if ();

    logic           push, full;
    decoded_instr_t dec_record, head;

    saturn_nibble_fetch fetch_i (
        .i_clk, .i_reset, .o_wb_cyc, .o_wb_stb, .o_wb_adr, .i_wb_dat, .i_wb_ack,
        .nib (nib_if.fetch)
    );

    saturn_inst_decoder decoder_i (
        .i_clk, .i_reset, .i_reg_p,
        .nib      (nib_if.decode),
        .o_push   (push),
        .o_record (dec_record),
        .i_full   (full),
        .o_decoder_error
    );

    saturn_decoded_queue queue_i (
        .i_clk, .i_reset,
        .i_push   (push),
        .i_record (dec_record),
        .o_full   (full),
        .o_valid, .i_ready,
        .o_record (head)
    );

    // head record out as one port per member.
    assign o_instr_pc      = head.pc;
    assign o_instr_type    = head.itype;
    assign o_alu_opcode    = head.opcode;
    assign o_alu_reg_dest  = head.dest;
    assign o_alu_reg_src   = head.src;
    assign o_alu_field     = head.field;
    assign o_alu_ptr_begin = head.ptr_begin;
    assign o_alu_ptr_end   = head.ptr_end;
    assign o_alu_imm       = head.imm;
    assign o_push_pc       = head.push_pc;
    assign o_operand       = head.operand;
    assign o_operand_len   = head.operand_len;

endmodule

`default_nettype wire

// File: verification/saturn_program.svh
//*********************************************************************
// test program and expected records, included inside the testbench.
// expected records assume i_reg_p held at REG_P (5).
// the program ends on nibble 7, which the decoder must reject.
//*********************************************************************
`ifndef SATURN_PROGRAM_SVH
`define SATURN_PROGRAM_SVH

localparam int PROGRAM_LEN = 90;

logic [3:0] prog_mem [PROGRAM_LEN] = '{
    4'h0, 4'h2, 4'h0, 4'h3, 4'h0, 4'h4, 4'h0, 4'h5, 4'h2, 4'h7,          // 0..9.
    4'h8, 4'h2, 4'h9, 4'h8, 4'h4, 4'h3, 4'h8, 4'h5, 4'hC,                // 10..18.
    4'h3, 4'h0, 4'hA, 4'h3, 4'h4, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5,          // LC 0, LC 4.
    4'h3, 4'hF, 4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7,          // LC 15.
    4'h8, 4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF,
    4'h6, 4'h1, 4'h2, 4'h3,                                              // GOTO at 47.
    4'h8, 4'hD, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5,                            // GOVLNG at 51.
    4'h8, 4'hF, 4'h5, 4'h4, 4'h3, 4'h2, 4'h1,                            // GOSBVL at 58.
    4'hA, 4'h0, 4'h8, 4'hA, 4'h1, 4'h9, 4'hA, 4'h2, 4'hA, 4'hA, 4'h3, 4'hB,
    4'hA, 4'h4, 4'h8, 4'hA, 4'h5, 4'h9, 4'hA, 4'h6, 4'hA, 4'hA, 4'h7, 4'hB,
    4'h7                                                                 // illegal.
};

task automatic load_expected();
    add_short("rtnsc", 0, ITYPE_RTN, ALU_OP_SET_CRY, ALU_REG_NONE, ALU_REG_NONE, 1, 0);
    add_short("rtncc", 2, ITYPE_RTN, ALU_OP_SET_CRY, ALU_REG_NONE, ALU_REG_NONE, 0, 0);
    add_short("sethex", 4, ITYPE_SET_MODE, ALU_OP_NOP, ALU_REG_NONE, ALU_REG_NONE, 0, 0);
    add_short("setdec", 6, ITYPE_SET_MODE, ALU_OP_NOP, ALU_REG_NONE, ALU_REG_NONE, 1, 0);
    add_short("p_eq_7", 8, ITYPE_ALU, ALU_OP_COPY, ALU_REG_P, ALU_REG_IMM, 7, 0);
    add_short("hst_clr", 10, ITYPE_ALU, ALU_OP_CLR_MASK, ALU_REG_HST, ALU_REG_IMM, 9, 0);
    add_short("st_clr", 13, ITYPE_ALU, ALU_OP_COPY, ALU_REG_ST, ALU_REG_IMM, 0, 3);
    add_short("st_set", 16, ITYPE_ALU, ALU_OP_COPY, ALU_REG_ST, ALU_REG_IMM, 1, 12);
    add_load("lc_0", 19, 5, 64'hA, 1);
    add_load("lc_4", 22, 9, 64'h54321, 5);
    add_load("lc_15", 29, 4, 64'hFEDC_BA98_7654_3210, 16);
    add_jump("goto", 47, 64'h321, 3, 1'b0);
    add_jump("govlng", 51, 64'h54321, 5, 1'b0);
    add_jump("gosbvl", 58, 64'h12345, 5, 1'b1);
    add_zero("zero_a_p", 65, ALU_REG_A, FIELD_P, REG_P, REG_P);
    add_zero("zero_b_wp", 68, ALU_REG_B, FIELD_WP, 0, REG_P);
    add_zero("zero_c_xs", 71, ALU_REG_C, FIELD_XS, 2, 2);
    add_zero("zero_d_x", 74, ALU_REG_D, FIELD_X, 0, 2);
    add_zero("zero_a_s", 77, ALU_REG_A, FIELD_S, 15, 15);
    add_zero("zero_b_m", 80, ALU_REG_B, FIELD_M, 3, 14);
    add_zero("zero_c_b", 83, ALU_REG_C, FIELD_B, 0, 1);
    add_zero("zero_d_w", 86, ALU_REG_D, FIELD_W, 0, 15);
endtask

`endif

// File: verification/saturn_decoder_tb.sv
//*********************************************************************
// testbench for the decoder top with a Wishbone memory model.
// ack delay and i_ready come from one LFSR, so the run repeats exactly.
// i_reg_p stays at 5 for the whole run.
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "saturn_cfg.svh"

module saturn_decoder_tb
    import saturn_pkg::*;
;
    localparam int REG_P = 5;

    logic i_clk = 1'b0;
    logic i_reset, i_wb_ack, i_ready;
    logic [3:0] i_wb_dat, i_reg_p;
    logic o_wb_cyc, o_wb_stb, o_valid, o_decoder_error, o_push_pc;
    logic [`SAT_ADDR_W-1:0] o_wb_adr, o_instr_pc;
    instr_type_e o_instr_type;
    alu_op_e o_alu_opcode;
    alu_reg_e o_alu_reg_dest, o_alu_reg_src;
    field_e o_alu_field;
    logic [3:0] o_alu_ptr_begin, o_alu_ptr_end, o_alu_imm;
    logic [63:0] o_operand;
    logic [4:0] o_operand_len;

    decoded_instr_t head, prev_head;
    decoded_instr_t exp_rec [$];
    string exp_name [$];
    int exp_idx = 0;
    int cycles = 0;
    int ack_wait = -1;
    int rst_edges = 0;
    logic prev_reset = 1'b1;
    logic hold_prev = 1'b0;
    logic err_seen = 1'b0;
    logic [31:0] lfsr = 32'h8990;
    logic [`SAT_ADDR_W-1:0] next_adr;

    saturn_decoder_top saturn_decoder_top_i (.*);

    always #10 i_clk = ~i_clk;

    always_comb begin
        head = '{pc: o_instr_pc, itype: o_instr_type, opcode: o_alu_opcode,
                 dest: o_alu_reg_dest, src: o_alu_reg_src, field: o_alu_field,
                 ptr_begin: o_alu_ptr_begin, ptr_end: o_alu_ptr_end, imm: o_alu_imm,
                 push_pc: o_push_pc, operand: o_operand, operand_len: o_operand_len};
    end

    task automatic fail_run(input string msg);
        $display("error: %s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp_v, act_v);
        $display("mismatch test=%s expected=%h actual=%h", name, exp_v, act_v);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // galois form, taps 32,30,26,25.
    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
    endtask

    // past the program, every address bit folds into the nibble.
    function automatic logic [3:0] fill_nibble(input logic [`SAT_ADDR_W-1:0] adr);
        fill_nibble = adr[3:0] ^ adr[7:4] ^ adr[11:8] ^ adr[15:12] ^ adr[19:16];
    endfunction

    function automatic decoded_instr_t base_rec(input int pc, input instr_type_e t,
                                                input alu_op_e op, input alu_reg_e d,
                                                input alu_reg_e s);
        base_rec = '{pc: pc, itype: t, opcode: op, dest: d, src: s, field: FIELD_NONE,
                     default: '0};
    endfunction

    task automatic store(input string name, input decoded_instr_t r);
        exp_rec.push_back(r);
        exp_name.push_back(name);
    endtask

    task automatic add_short(input string name, input int pc, input instr_type_e t,
                             input alu_op_e op, input alu_reg_e d, input alu_reg_e s,
                             input int imm, input int ptr);
        decoded_instr_t r;
        r = base_rec(pc, t, op, d, s);
        r.imm = imm;
        r.ptr_begin = ptr;
        r.ptr_end = ptr;
        store(name, r);
    endtask

    task automatic add_load(input string name, input int pc, input int pe,
                            input logic [63:0] operand, input int len);
        decoded_instr_t r;
        r = base_rec(pc, ITYPE_LOAD, ALU_OP_NOP, ALU_REG_C, ALU_REG_NONE);
        r.ptr_begin = REG_P;
        r.ptr_end = pe;                             // (P+n) mod 16.
        r.operand = operand;
        r.operand_len = len;
        store(name, r);
    endtask

    task automatic add_jump(input string name, input int pc, input logic [63:0] operand,
                            input int len, input logic push);
        decoded_instr_t r;
        r = base_rec(pc, ITYPE_JUMP, ALU_OP_NOP, ALU_REG_NONE, ALU_REG_NONE);
        r.operand = operand;
        r.operand_len = len;
        r.push_pc = push;
        store(name, r);
    endtask

    task automatic add_zero(input string name, input int pc, input alu_reg_e d,
                            input field_e f, input int pb, input int pe);
        decoded_instr_t r;
        r = base_rec(pc, ITYPE_ALU, ALU_OP_ZERO, d, ALU_REG_NONE);
        r.field = f;
        r.ptr_begin = pb;
        r.ptr_end = pe;
        store(name, r);
    endtask

    `include "saturn_program.svh"

    localparam int TIMEOUT = 16 * PROGRAM_LEN + 200;

    // memory slave and ready, one LFSR stream in a fixed order.
    always @(posedge i_clk) begin
        int r;
        if (i_reset) begin
            i_wb_ack <= 1'b0;
            i_ready  <= 1'b0;
            ack_wait = -1;
            next_adr = `SAT_RESET_PC;
        end else begin
            draw_bits(1, r);
            i_ready <= r[0];
            if (i_wb_ack) begin
                i_wb_ack <= 1'b0;                   // cyc drops on this edge.
                ack_wait = -1;
            end else if (o_wb_cyc && o_wb_stb) begin
                if (ack_wait < 0) begin
                    assert (o_wb_adr == next_adr)
                    else report_mismatch("wb_address", next_adr, o_wb_adr);
                    next_adr = next_adr + 1'b1;
                    draw_bits(2, ack_wait);         // 0..3 wait cycles.
                end
                if (ack_wait == 0) begin
                    i_wb_ack <= 1'b1;
                    i_wb_dat <= (o_wb_adr < PROGRAM_LEN) ? prog_mem[o_wb_adr]
                                                         : fill_nibble(o_wb_adr);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > TIMEOUT)
            fail_run($sformatf("run timed out after %0d cycles", TIMEOUT));
        if (rst_edges > 0 && (i_reset || prev_reset))
            assert (!o_valid && !o_wb_cyc && !o_wb_stb && !o_decoder_error)
            else fail_run("outputs not idle during or right after reset");
        if (i_reset)
            rst_edges++;
        prev_reset = i_reset;
        if (hold_prev)
            assert (o_valid && head == prev_head)
            else report_mismatch("hold", prev_head, head);
        if (!i_reset && o_valid && i_ready) begin
            assert (exp_idx < exp_rec.size())
            else fail_run("record received after the last expected one");
            assert (head == exp_rec[exp_idx])
            else report_mismatch(exp_name[exp_idx], exp_rec[exp_idx], head);
            exp_idx++;
        end
        hold_prev = !i_reset && o_valid && !i_ready;
        prev_head = head;
        if (err_seen)
            assert (o_decoder_error) else fail_run("decoder error flag dropped without reset");
        err_seen = !i_reset && (err_seen || o_decoder_error);
    end

    initial begin
        i_reset  = 1'b1;
        i_wb_ack = 1'b0;
        i_wb_dat = 4'h0;
        i_ready  = 1'b0;
        i_reg_p  = REG_P;
        load_expected();
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        wait (exp_idx == exp_rec.size());
        repeat (20) begin
            @(posedge i_clk);
            assert (!o_valid) else fail_run("record offered after the illegal opcode");
        end
        if (o_decoder_error) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("decoder error flag not set by the illegal opcode");
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
+incdir+verification
design/saturn_pkg.sv
design/saturn_nibble_if.sv
design/saturn_nibble_fetch.sv
design/saturn_field_table.sv
design/saturn_inst_decoder.sv
design/saturn_decoded_queue.sv
design/saturn_decoder_top.sv
verification/saturn_decoder_tb.sv

// File: Bender.yml
package:
  name: saturn_decoder

sources:
  - include_dirs:
      - design
    files:
      - design/saturn_pkg.sv
      - design/saturn_nibble_if.sv
      - design/saturn_nibble_fetch.sv
      - design/saturn_field_table.sv
      - design/saturn_inst_decoder.sv
      - design/saturn_decoded_queue.sv
      - design/saturn_decoder_top.sv
  - target: test
    include_dirs:
      - design
      - verification
    files:
      - verification/saturn_decoder_tb.sv
